// File: rv_memstage_macros.svh
`ifndef RV_MEMSTAGE_MACROS_SVH
`define RV_MEMSTAGE_MACROS_SVH

// data and address width
`define XLEN 32

// depth of the data memory in words
`define MEM_WORDS 1024

// cycles from an accepted request to its response
`define MEM_LATENCY 3

`endif

// File: rv_memstage_pkg.sv
`default_nettype none

`include "rv_memstage_macros.svh"

package rv_memstage_pkg;

    typedef logic [`XLEN-1:0] uint_x;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE,
        MEM_ATOMIC
    } mem_op_e;

    // a-extension sub-operations
    typedef enum logic [3:0] {
        AMO_LR,
        AMO_SC,
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,
        AMO_MAX
    } aext_op_e;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    typedef enum logic {
        OP_SIGNED,
        OP_UNSIGNED
    } sign_e;

    // mcause codes
    typedef enum logic [3:0] {
        CAUSE_LOAD_ACCESS_FAULT      = 4'd5,
        CAUSE_STORE_AMO_ACCESS_FAULT = 4'd7
    } trap_cause_e;

    typedef struct packed {
        mem_op_e   op;
        aext_op_e  a_op;
        mem_size_e size;
        sign_e     sign;
    } mem_ctrl_t;

    typedef struct packed {
        logic        valid;
        trap_cause_e cause;
    } trap_info_t;

    typedef struct packed {
        logic      valid;
        logic      wen;
        uint_x     addr;
        uint_x     wdata;  // already placed in its byte lanes
        mem_size_e size;
    } cache_req_t;

    typedef struct packed {
        logic  valid;
        logic  error;
        uint_x rdata;  // shifted down by the byte offset
    } cache_resp_t;

endpackage

`default_nettype wire

// File: amo_alu.sv
`default_nettype none

module amo_alu
    import rv_memstage_pkg::*;
(
    input  aext_op_e a_op,
    input  sign_e    sign,
    input  uint_x    mem_rdata,
    input  uint_x    rs2_data,
    output uint_x    wdata
);

    logic mem_less;  // memory word below rs2

    always_comb begin
        if (sign == OP_SIGNED) begin
            mem_less = $signed(mem_rdata) < $signed(rs2_data);
        end else begin
            mem_less = mem_rdata < rs2_data;
        end
    end

    always_comb begin
        case (a_op)
            AMO_SWAP: wdata = rs2_data;
            AMO_ADD:  wdata = mem_rdata + rs2_data;
            AMO_XOR:  wdata = mem_rdata ^ rs2_data;
            AMO_AND:  wdata = mem_rdata & rs2_data;
            AMO_OR:   wdata = mem_rdata | rs2_data;
            AMO_MIN:  wdata = mem_less ? mem_rdata : rs2_data;
            AMO_MAX:  wdata = mem_less ? rs2_data : mem_rdata;
            default:  wdata = rs2_data;  // lr, sc write rs2 as is
        endcase
    end

endmodule

`default_nettype wire

// File: mem_stage.sv
`default_nettype none

module mem_stage
    import rv_memstage_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        valid,
    input  mem_ctrl_t   ctrl,
    input  uint_x       alu_out,
    input  uint_x       rs2_data,
    input  trap_info_t  trapinfo,
    output trap_info_t  next_trapinfo,
    output uint_x       next_mem_rdata,
    output logic        is_stall,
    output cache_req_t  req,
    input  logic        req_ready,
    input  cache_resp_t resp
);

    localparam int XW = $bits(uint_x);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_READY,
        S_WAIT_READ,
        S_WAIT_WRITE
    } state_e;

    state_e state;
    logic   done;        // instruction finished, waiting for the pipeline
    logic   amo_write;   // second phase of a read-modify-write
    logic   saved_error;
    uint_x  saved_rdata;
    logic   sc_ok;
    logic   resv_valid;
    uint_x  resv_addr;

    uint_x  amo_wdata;
    uint_x  store_word;
    uint_x  rdata_fmt;
    logic   is_lr;
    logic   is_sc;
    logic   is_rmw;
    logic   is_load_like;

    assign is_lr        = ctrl.op == MEM_ATOMIC && ctrl.a_op == AMO_LR;
    assign is_sc        = ctrl.op == MEM_ATOMIC && ctrl.a_op == AMO_SC;
    assign is_rmw       = ctrl.op == MEM_ATOMIC && !is_lr && !is_sc;
    assign is_load_like = ctrl.op == MEM_LOAD || is_lr;

    amo_alu u_amo_alu (
        .a_op      (ctrl.a_op),
        .sign      (ctrl.sign),
        .mem_rdata (saved_rdata),
        .rs2_data  (rs2_data),
        .wdata     (amo_wdata)
    );

    assign store_word = amo_write ? amo_wdata : rs2_data;

    assign req.valid = state == S_WAIT_READY;
    assign req.wen   = ctrl.op == MEM_STORE || is_sc || amo_write;
    assign req.addr  = alu_out;
    assign req.wdata = store_word << {alu_out[1:0], 3'b000};  // into its lanes
    assign req.size  = ctrl.op == MEM_ATOMIC ? SIZE_W : ctrl.size;

    assign is_stall = valid && ctrl.op != MEM_NONE && (state != S_IDLE || !done);

    always_comb begin
        rdata_fmt = '0;
        case (ctrl.op)
            MEM_LOAD: begin
                case (ctrl.size)
                    SIZE_B: begin
                        rdata_fmt = {{(XW-8){ctrl.sign == OP_SIGNED && saved_rdata[7]}},
                                     saved_rdata[7:0]};
                    end
                    SIZE_H: begin
                        rdata_fmt = {{(XW-16){ctrl.sign == OP_SIGNED && saved_rdata[15]}},
                                     saved_rdata[15:0]};
                    end
                    default: rdata_fmt = saved_rdata;
                endcase
            end
            MEM_ATOMIC: begin
                if (is_sc) begin
                    rdata_fmt = sc_ok ? '0 : uint_x'(1);
                end else begin
                    rdata_fmt = saved_rdata;  // lr and amo give the old word
                end
            end
            default: rdata_fmt = '0;
        endcase
    end

    assign next_mem_rdata = rdata_fmt;

    always_comb begin
        if (ctrl.op == MEM_NONE) begin
            next_trapinfo = trapinfo;
        end else begin
            next_trapinfo.valid = saved_error;
            next_trapinfo.cause = is_load_like ? CAUSE_LOAD_ACCESS_FAULT
                                               : CAUSE_STORE_AMO_ACCESS_FAULT;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_IDLE;
            done        <= 1'b0;
            amo_write   <= 1'b0;
            saved_error <= 1'b0;
            resv_valid  <= 1'b0;
        end else if (!valid || ctrl.op == MEM_NONE) begin
            state     <= S_IDLE;
            done      <= 1'b0;
            amo_write <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!done) begin
                        amo_write   <= 1'b0;
                        saved_error <= 1'b0;
                        if (is_sc) begin
                            resv_valid <= 1'b0;  // any sc drops the reservation
                            if (resv_valid && resv_addr == alu_out) begin
                                sc_ok <= 1'b1;
                                state <= S_WAIT_READY;
                            end else begin
                                sc_ok <= 1'b0;
                                done  <= 1'b1;
                            end
                        end else begin
                            if (is_lr) begin
                                resv_valid <= 1'b1;
                                resv_addr  <= alu_out;
                            end
                            state <= S_WAIT_READY;
                        end
                    end
                end
                S_WAIT_READY: begin
                    if (req_ready) begin
                        state <= req.wen ? S_WAIT_WRITE : S_WAIT_READ;
                    end
                end
                S_WAIT_READ: begin
                    if (resp.valid) begin
                        saved_rdata <= resp.rdata;
                        saved_error <= resp.error;
                        if (is_rmw && !resp.error) begin
                            amo_write <= 1'b1;
                            state     <= S_WAIT_READY;
                        end else begin
                            state <= S_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                default: begin  // write response
                    if (resp.valid) begin
                        saved_error <= resp.error;
                        state       <= S_IDLE;
                        done        <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: data_ram.sv
`default_nettype none

`include "rv_memstage_macros.svh"

module data_ram
    import rv_memstage_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  cache_req_t  req,
    output logic        req_ready,
    output cache_resp_t resp
);

    localparam int LANES = `XLEN / 8;
    localparam int OFF_W = $clog2(LANES);
    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    uint_x mem [`MEM_WORDS];

    logic             busy;
    logic [CNT_W-1:0] count;
    logic             finish;
    uint_x            hold_addr;
    logic             hold_wen;
    uint_x            hold_wdata;
    mem_size_e        hold_size;
    logic [LANES-1:0] lane_mask;
    logic [IDX_W-1:0] idx;
    logic [OFF_W-1:0] off;
    logic             out_of_range;

    logic  resp_valid;
    logic  resp_error;
    uint_x resp_rdata;

    assign req_ready    = !busy;
    assign finish       = busy && count == CNT_W'(1);
    assign idx          = hold_addr[OFF_W +: IDX_W];
    assign off          = hold_addr[OFF_W-1:0];
    assign out_of_range = hold_addr >= uint_x'(`MEM_WORDS * LANES);

    always_comb begin
        case (hold_size)
            SIZE_B:  lane_mask = LANES'(1) << off;
            SIZE_H:  lane_mask = LANES'(3) << off;
            default: lane_mask = '1;
        endcase
    end

    // countdown from accept to response
    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            count      <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (!busy) begin
                if (req.valid) begin
                    busy  <= 1'b1;
                    count <= CNT_W'(`MEM_LATENCY);
                end
            end else begin
                count <= count - 1'b1;
                if (finish) begin
                    busy       <= 1'b0;
                    resp_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && req.valid) begin
            hold_addr  <= req.addr;
            hold_wen   <= req.wen;
            hold_wdata <= req.wdata;
            hold_size  <= req.size;
        end
        if (finish) begin
            resp_error <= out_of_range;
            resp_rdata <= out_of_range ? '0 : mem[idx] >> {off, 3'b000};
            if (hold_wen && !out_of_range) begin
                for (int i = 0; i < LANES; i++) begin
                    if (lane_mask[i]) mem[idx][8*i +: 8] <= hold_wdata[8*i +: 8];
                end
            end
        end
    end

    assign resp.valid = resp_valid;
    assign resp.error = resp_error;
    assign resp.rdata = resp_rdata;

endmodule

`default_nettype wire

// File: rv_memstage_top.sv
`default_nettype none

module rv_memstage_top
    import rv_memstage_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       valid,
    input  mem_ctrl_t  ctrl,
    input  uint_x      alu_out,
    input  uint_x      rs2_data,
    input  trap_info_t trapinfo,
    output trap_info_t next_trapinfo,
    output uint_x      next_mem_rdata,
    output logic       is_stall
);

    cache_req_t  req;
    logic        req_ready;
    cache_resp_t resp;

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .valid          (valid),
        .ctrl           (ctrl),
        .alu_out        (alu_out),
        .rs2_data       (rs2_data),
        .trapinfo       (trapinfo),
        .next_trapinfo  (next_trapinfo),
        .next_mem_rdata (next_mem_rdata),
        .is_stall       (is_stall),
        .req            (req),
        .req_ready      (req_ready),
        .resp           (resp)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_ready (req_ready),
        .resp      (resp)
    );

endmodule

`default_nettype wire

// File: tb_rv_memstage.sv
`default_nettype none

`include "rv_memstage_macros.svh"

module tb_rv_memstage
    import rv_memstage_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT = 4000;
    localparam int MEM_BYTES   = `MEM_WORDS * 4;

    logic       clk;
    logic       reset;
    logic       valid;
    mem_ctrl_t  ctrl;
    uint_x      alu_out;
    uint_x      rs2_data;
    trap_info_t trapinfo;
    trap_info_t next_trapinfo;
    uint_x      next_mem_rdata;
    logic       is_stall;

    logic [31:0] seed = 32'h5d5c;
    logic [7:0]  ref_mem [MEM_BYTES];  // byte-accurate model of the data memory
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    rv_memstage_top u_rv_memstage_top (
        .clk            (clk),
        .reset          (reset),
        .valid          (valid),
        .ctrl           (ctrl),
        .alu_out        (alu_out),
        .rs2_data       (rs2_data),
        .trapinfo       (trapinfo),
        .next_trapinfo  (next_trapinfo),
        .next_mem_rdata (next_mem_rdata),
        .is_stall       (is_stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic uint_x next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic uint_x rand_addr();
        return (next_rand() % `MEM_WORDS) * 4;  // word aligned, in range
    endfunction

    function automatic mem_ctrl_t make_ctrl(mem_op_e op, aext_op_e a_op, mem_size_e size,
                                            sign_e sign);
        mem_ctrl_t c;
        c.op   = op;
        c.a_op = a_op;
        c.size = size;
        c.sign = sign;
        return c;
    endfunction

    function automatic uint_x ref_read(uint_x addr, mem_size_e size, sign_e sign);
        logic msb;
        case (size)
            SIZE_B: begin
                msb = sign == OP_SIGNED && ref_mem[addr][7];
                return {{24{msb}}, ref_mem[addr]};
            end
            SIZE_H: begin
                msb = sign == OP_SIGNED && ref_mem[addr+1][7];
                return {{16{msb}}, ref_mem[addr+1], ref_mem[addr]};
            end
            default: return {ref_mem[addr+3], ref_mem[addr+2], ref_mem[addr+1], ref_mem[addr]};
        endcase
    endfunction

    function automatic void ref_write(uint_x addr, mem_size_e size, uint_x data);
        int n;
        n = size == SIZE_B ? 1 : (size == SIZE_H ? 2 : 4);
        for (int i = 0; i < n; i++) begin
            ref_mem[addr+i] = data[8*i +: 8];
        end
    endfunction

    // word written back by an atomic
    function automatic uint_x amo_result(aext_op_e op, sign_e sign, uint_x old, uint_x rs2);
        uint_x bias;
        logic  old_below;
        bias      = sign == OP_SIGNED ? 32'h8000_0000 : 32'h0;
        old_below = (old ^ bias) < (rs2 ^ bias);  // flipped msb orders signed as unsigned
        case (op)
            AMO_ADD: return old + rs2;
            AMO_XOR: return old ^ rs2;
            AMO_AND: return old & rs2;
            AMO_OR:  return old | rs2;
            AMO_MIN: return old_below ? old : rs2;
            AMO_MAX: return old_below ? rs2 : old;
            default: return rs2;
        endcase
    endfunction

    task automatic check(string name, uint_x expected, uint_x actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one instruction, held until the stage releases it
    task automatic execute(input mem_ctrl_t c, input uint_x addr, input uint_x wdata,
                           input trap_info_t ti, output uint_x rdata,
                           output trap_info_t trap, output int stalls);
        ctrl     = c;
        alu_out  = addr;
        rs2_data = wdata;
        trapinfo = ti;
        valid    = 1'b1;
        stalls   = 0;
        @(negedge clk);
        while (is_stall) begin
            stalls++;
            @(negedge clk);
        end
        rdata = next_mem_rdata;
        trap  = next_trapinfo;
        valid = 1'b0;  // bubble before the next one
        @(negedge clk);
    endtask

    task automatic store(uint_x addr, mem_size_e size, uint_x data);
        uint_x      rd;
        trap_info_t tr;
        int         stalls;
        execute(make_ctrl(MEM_STORE, AMO_LR, size, OP_SIGNED), addr, data, '0, rd, tr, stalls);
        check("store trap valid", 0, tr.valid);
        ref_write(addr, size, data);
    endtask

    task automatic load(uint_x addr, mem_size_e size, sign_e sign, string name);
        uint_x      rd;
        trap_info_t tr;
        int         stalls;
        execute(make_ctrl(MEM_LOAD, AMO_LR, size, sign), addr, '0, '0, rd, tr, stalls);
        check(name, ref_read(addr, size, sign), rd);
        check({name, " trap valid"}, 0, tr.valid);
    endtask

    task automatic amo(aext_op_e op, sign_e sign, uint_x addr, uint_x rs2,
                       output uint_x rd, output trap_info_t tr);
        int stalls;
        execute(make_ctrl(MEM_ATOMIC, op, SIZE_W, sign), addr, rs2, '0, rd, tr, stalls);
    endtask

    task automatic expect_fault(string name, mem_ctrl_t c, uint_x addr, trap_cause_e cause);
        uint_x      rd;
        trap_info_t tr;
        int         stalls;
        execute(c, addr, next_rand(), '0, rd, tr, stalls);
        check({name, " trap valid"}, 1, tr.valid);
        check({name, " trap cause"}, cause, tr.cause);
    endtask

    task automatic test_word_rw();
        uint_x addrs [16];
        for (int i = 0; i < 16; i++) begin
            addrs[i] = rand_addr();
            store(addrs[i], SIZE_W, next_rand());
        end
        for (int i = 0; i < 16; i++) begin
            load(addrs[i], SIZE_W, OP_UNSIGNED, "word load");
        end
    endtask

    task automatic test_sub_word();
        uint_x base;
        for (int r = 0; r < 4; r++) begin
            base = rand_addr();
            store(base, SIZE_W, next_rand());
            store(base + next_rand() % 4, SIZE_B, next_rand());
            store(base + (next_rand() % 2) * 2, SIZE_H, next_rand());
            for (int k = 0; k < 4; k++) begin
                load(base + k, SIZE_B, OP_SIGNED, "lb");
                load(base + k, SIZE_B, OP_UNSIGNED, "lbu");
            end
            for (int k = 0; k < 4; k += 2) begin
                load(base + k, SIZE_H, OP_SIGNED, "lh");
                load(base + k, SIZE_H, OP_UNSIGNED, "lhu");
            end
            load(base, SIZE_W, OP_SIGNED, "lw after byte and half stores");
        end
    endtask

    task automatic test_lr_sc();
        uint_x      a;
        uint_x      b;
        uint_x      v;
        uint_x      rd;
        trap_info_t tr;
        a = (next_rand() % (`MEM_WORDS - 1)) * 4;
        b = a + 4;  // neighbour word
        store(a, SIZE_W, next_rand());
        store(b, SIZE_W, next_rand());
        amo(AMO_LR, OP_SIGNED, a, '0, rd, tr);
        check("lr old word", ref_read(a, SIZE_W, OP_UNSIGNED), rd);
        v = next_rand();
        amo(AMO_SC, OP_SIGNED, a, v, rd, tr);
        check("sc after lr", 0, rd);
        ref_write(a, SIZE_W, v);
        load(a, SIZE_W, OP_UNSIGNED, "word after sc");
        amo(AMO_SC, OP_SIGNED, a, next_rand(), rd, tr);
        check("second sc", 1, rd);
        load(a, SIZE_W, OP_UNSIGNED, "word after second sc");
        amo(AMO_LR, OP_SIGNED, a, '0, rd, tr);
        amo(AMO_SC, OP_SIGNED, b, next_rand(), rd, tr);
        check("sc to other address", 1, rd);
        load(b, SIZE_W, OP_UNSIGNED, "word after sc to other address");
    endtask

    task automatic test_atomics();
        aext_op_e   ops [9]   = '{AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR,
                                  AMO_MIN, AMO_MIN, AMO_MAX, AMO_MAX};
        sign_e      signs [9] = '{OP_SIGNED, OP_SIGNED, OP_SIGNED, OP_SIGNED, OP_SIGNED,
                                  OP_SIGNED, OP_UNSIGNED, OP_SIGNED, OP_UNSIGNED};
        uint_x      addr;
        uint_x      old;
        uint_x      rs2;
        uint_x      rd;
        trap_info_t tr;
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 9; i++) begin
                addr = rand_addr();
                old  = next_rand();
                rs2  = next_rand();
                store(addr, SIZE_W, old);
                amo(ops[i], signs[i], addr, rs2, rd, tr);
                check($sformatf("%s old word", ops[i].name()), old, rd);
                check($sformatf("%s trap valid", ops[i].name()), 0, tr.valid);
                ref_write(addr, SIZE_W, amo_result(ops[i], signs[i], old, rs2));
                load(addr, SIZE_W, OP_UNSIGNED, $sformatf("%s new word", ops[i].name()));
            end
        end
    endtask

    task automatic test_access_fault();
        uint_x bad;
        uint_x shadow;
        for (int r = 0; r < 2; r++) begin
            bad    = r == 0 ? MEM_BYTES : MEM_BYTES + (next_rand() % 4096) * 4;
            shadow = bad % MEM_BYTES;  // in-range word with the same index bits
            store(shadow, SIZE_W, next_rand());
            expect_fault("load", make_ctrl(MEM_LOAD, AMO_LR, SIZE_W, OP_SIGNED), bad,
                         CAUSE_LOAD_ACCESS_FAULT);
            expect_fault("lr", make_ctrl(MEM_ATOMIC, AMO_LR, SIZE_W, OP_SIGNED), bad,
                         CAUSE_LOAD_ACCESS_FAULT);
            // reservation from the lr above lets the sc go out
            expect_fault("sc", make_ctrl(MEM_ATOMIC, AMO_SC, SIZE_W, OP_SIGNED), bad,
                         CAUSE_STORE_AMO_ACCESS_FAULT);
            expect_fault("store", make_ctrl(MEM_STORE, AMO_LR, SIZE_W, OP_SIGNED), bad,
                         CAUSE_STORE_AMO_ACCESS_FAULT);
            expect_fault("amoadd", make_ctrl(MEM_ATOMIC, AMO_ADD, SIZE_W, OP_SIGNED), bad,
                         CAUSE_STORE_AMO_ACCESS_FAULT);
            load(shadow, SIZE_W, OP_UNSIGNED, "word under faulting writes");
        end
    endtask

    task automatic test_no_op();
        trap_info_t ti;
        trap_info_t tr;
        uint_x      rd;
        int         stalls;
        for (int i = 0; i < 4; i++) begin
            ti.valid = i[0];
            ti.cause = i[1] ? CAUSE_STORE_AMO_ACCESS_FAULT : CAUSE_LOAD_ACCESS_FAULT;
            execute(make_ctrl(MEM_NONE, AMO_LR, SIZE_W, OP_SIGNED), rand_addr(), next_rand(),
                    ti, rd, tr, stalls);
            check("op none stall cycles", 0, stalls);
            check("op none trapinfo", ti, tr);
        end
    endtask

    initial begin
        reset    = 1'b1;
        valid    = 1'b0;
        ctrl     = '0;
        alu_out  = '0;
        rs2_data = '0;
        trapinfo = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_no_op();
        test_word_rw();
        test_sub_word();
        test_lr_sc();
        test_atomics();
        test_access_fault();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_memstage.f
+incdir+.
rv_memstage_pkg.sv
amo_alu.sv
mem_stage.sv
data_ram.sv
rv_memstage_top.sv
tb_rv_memstage.sv

// File: Bender.yml
package:
  name: rv_memstage

export_include_dirs:
  - .

sources:
  - files:
      - rv_memstage_pkg.sv
      - amo_alu.sv
      - mem_stage.sv
      - data_ram.sv
      - rv_memstage_top.sv
  - target: test
    files:
      - tb_rv_memstage.sv
